// ==== all.f ====
+incdir+include
src/mult_pkg.sv
src/mult_operand_select.sv
src/mult_stage.sv
src/mult_result_drain.sv
src/mult_unit.sv
verification/mult_unit_tb.sv

// ==== src/mult_operand_select.sv ====
`timescale 1ns/1ps

module mult_operand_select import mult_pkg::*; (
  input  mult_issue_t issue,
  input  logic        rollback_en,
  input  rob_idx_t    rollback_idx,
  input  rob_idx_t    rob_tail_idx,
  output mult_entry_t stage_in,
  output rollback_t   rollback
);

  word_t opb;

  // register value or zero-extended literal
  always_comb begin
    if (issue.imm_select) begin
      opb = {{(XLEN-IMM_W){1'b0}}, issue.imm};
    end else begin
      opb = issue.opb_reg;
    end
  end

  // first stage starts from an empty accumulator
  always_comb begin
    stage_in.done     = issue.ready;
    stage_in.product  = '0;
    stage_in.mplier   = issue.opa;
    stage_in.mcand    = opb;
    stage_in.dest_idx = issue.dest_idx;
    stage_in.t_idx    = issue.t_idx;
    stage_in.rob_idx  = issue.rob_idx;
  end

  // window computed once here and shared by every stage and the drain
  always_comb begin
    rollback.en           = rollback_en;
    rollback.rollback_idx = rollback_idx;
    rollback.window       = rob_tail_idx - rollback_idx;
  end

  // issue stage keeps the literal field clear on register-register ops
  always_comb begin
    if (issue.ready && !issue.imm_select) begin
      imm_clear_for_reg_op: assert final (issue.imm == '0)
        else $error("literal field set on a register-register multiply");
    end
  end

endmodule

// ==== src/mult_pkg.sv ====
package mult_pkg;

  // datapath
  localparam int XLEN        = 64;
  localparam int MULT_STAGES = 4;
  // multiplier bits retired by each stage
  localparam int SLICE_W     = XLEN / MULT_STAGES;

  // reorder buffer and physical register file
  localparam int ROB_ENTRIES = 32;
  localparam int ROB_IDX_W   = $clog2(ROB_ENTRIES);
  localparam int PR_ENTRIES  = 64;
  localparam int PR_IDX_W    = $clog2(PR_ENTRIES);

  localparam int ARCH_REG_W  = 5;
  localparam int IMM_W       = 8;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [ROB_IDX_W-1:0]  rob_idx_t;
  typedef logic [PR_IDX_W-1:0]   pr_idx_t;
  typedef logic [ARCH_REG_W-1:0] arch_reg_t;
  typedef logic [IMM_W-1:0]      imm_t;

  // instruction as it leaves the issue stage
  typedef struct packed {
    logic      ready;
    word_t     opa;
    word_t     opb_reg;
    imm_t      imm;
    // high picks the literal as operand B
    logic      imm_select;
    arch_reg_t dest_idx;
    pr_idx_t   t_idx;
    rob_idx_t  rob_idx;
  } mult_issue_t;

  // contents of one pipeline stage
  typedef struct packed {
    logic      done;
    word_t     product;
    word_t     mplier;
    word_t     mcand;
    arch_reg_t dest_idx;
    pr_idx_t   t_idx;
    rob_idx_t  rob_idx;
  } mult_entry_t;

  // packet presented to the common data bus
  typedef struct packed {
    logic      done;
    word_t     result;
    arch_reg_t dest_idx;
    pr_idx_t   t_idx;
    rob_idx_t  rob_idx;
  } mult_result_t;

  // rollback broadcast, window is tail minus rollback index
  typedef struct packed {
    logic     en;
    rob_idx_t rollback_idx;
    rob_idx_t window;
  } rollback_t;

  // true when rob_idx sits inside the squashed span, both ends included
  function automatic logic squash_hit(rob_idx_t rob_idx, rollback_t rollback);
    rob_idx_t offset;
    // wraps modulo the ROB size
    offset = rob_idx - rollback.rollback_idx;
    return rollback.en && (offset <= rollback.window);
  endfunction

endpackage

// ==== src/mult_result_drain.sv ====
`timescale 1ns/1ps

module mult_result_drain import mult_pkg::*; (
  input  mult_entry_t  last_entry,
  input  rollback_t    rollback,
  input  logic         cdb_grant,
  output mult_result_t result,
  output logic         advance
);

  logic squash_last;

  // final entry can be hit by a rollback in the same cycle it is shown
  assign squash_last = squash_hit(last_entry.rob_idx, rollback);

  always_comb begin
    result.done     = last_entry.done && !squash_last;
    result.result   = last_entry.product;
    result.dest_idx = last_entry.dest_idx;
    result.t_idx    = last_entry.t_idx;
    result.rob_idx  = last_entry.rob_idx;
  end

  // stall only while a live result is waiting on the bus
  assign advance = !result.done || cdb_grant;

endmodule

// ==== src/mult_stage.sv ====
`timescale 1ns/1ps

module mult_stage import mult_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        advance,
  input  rollback_t   rollback,
  input  mult_entry_t entry_in,
  output mult_entry_t entry_out
);

  word_t       partial;
  mult_entry_t next_entry;
  logic        squash_in;
  logic        squash_held;

  // low slice of the multiplier against the full multiplicand
  assign partial = word_t'(entry_in.mplier[SLICE_W-1:0]) * entry_in.mcand;

  assign squash_in   = squash_hit(entry_in.rob_idx, rollback);
  assign squash_held = squash_hit(entry_out.rob_idx, rollback);

  always_comb begin
    next_entry         = entry_in;
    next_entry.product = entry_in.product + partial;
    // next stage sees the following slice in the low bits
    next_entry.mplier  = entry_in.mplier >> SLICE_W;
    // multiplicand moves up to the weight of that slice
    next_entry.mcand   = entry_in.mcand << SLICE_W;
    next_entry.done    = entry_in.done && !squash_in;
  end

  // whole pipe moves or holds together on the shared advance level
  always_ff @(posedge clock) begin
    if (advance) begin
      entry_out <= next_entry;
    end
    if (reset) begin
      entry_out.done <= 1'b0;
    end else if (!advance && squash_held) begin
      // held entry killed in place while stalled
      entry_out.done <= 1'b0;
    end
  end

  // nothing valid leaves a stage straight out of reset
  done_low_after_reset: assert property (
    @(posedge clock) reset |=> !entry_out.done
  ) else $error("stage entry valid in the cycle after reset");

endmodule

// ==== src/mult_unit.sv ====
`timescale 1ns/1ps

module mult_unit import mult_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  mult_issue_t  issue,
  input  logic         cdb_grant,
  input  logic         rollback_en,
  input  rob_idx_t     rollback_idx,
  input  rob_idx_t     rob_tail_idx,
  output mult_result_t result,
  output logic         issue_accept
);

  // stage_chain[0] is the feeder output, stage_chain[i+1] the output of stage i
  mult_entry_t stage_chain [MULT_STAGES+1];
  rollback_t   rollback;
  logic        advance;

  mult_operand_select operand_select_inst (
    .issue        (issue),
    .rollback_en  (rollback_en),
    .rollback_idx (rollback_idx),
    .rob_tail_idx (rob_tail_idx),
    .stage_in     (stage_chain[0]),
    .rollback     (rollback)
  );

  for (genvar i = 0; i < MULT_STAGES; i++) begin : g_stage
    mult_stage stage_inst (
      .clock     (clock),
      .reset     (reset),
      .advance   (advance),
      .rollback  (rollback),
      .entry_in  (stage_chain[i]),
      .entry_out (stage_chain[i+1])
    );
  end

  mult_result_drain result_drain_inst (
    .last_entry (stage_chain[MULT_STAGES]),
    .rollback   (rollback),
    .cdb_grant  (cdb_grant),
    .result     (result),
    .advance    (advance)
  );

  // a new issue is taken exactly when the pipe moves
  assign issue_accept = advance;

  // stalled result stays put unless a rollback masks it
  result_stable_on_stall: assert property (
    @(posedge clock) disable iff (reset)
    !advance && !rollback_en |=> $stable(result) || rollback_en
  ) else $error("result changed while the bus held the unit");

endmodule

// ==== include/mult_tb_tasks.svh ====
`ifndef MULT_TB_TASKS_SVH
`define MULT_TB_TASKS_SVH

// move to the drive point of the next cycle
task automatic tick();
  @(posedge clock);
  #(DRIVE_DELAY);
endtask

// mid-cycle sample point, outputs are settled here
task automatic settle();
  @(negedge clock);
endtask

task automatic report_mismatch(input string msg);
  $display("FAILED at %0t ns: %s", $time, msg);
  $display("CHECKS FAILED");
  $fatal(1, "stopped at the first mismatch");
endtask

task automatic report_problem(input string msg);
  $display("%s", msg);
  $display("CHECKS FAILED");
  $fatal(1, "stopped after a protocol problem");
endtask

task automatic check_word(input string what, input word_t actual, input word_t expected);
  if (actual !== expected) begin
    report_mismatch($sformatf("%s is %h, expected %h", what, actual, expected));
  end
endtask

task automatic check_tags(input rob_idx_t rob_actual, input rob_idx_t rob_expected,
                          input pr_idx_t t_actual, input pr_idx_t t_expected);
  if (rob_actual !== rob_expected || t_actual !== t_expected) begin
    report_mismatch($sformatf("tags rob %0d t %0d, expected rob %0d t %0d",
                              rob_actual, t_actual, rob_expected, t_expected));
  end
endtask

task automatic check_dest(input arch_reg_t actual, input arch_reg_t expected);
  if (actual !== expected) begin
    report_mismatch($sformatf("dest_idx is %0d, expected %0d", actual, expected));
  end
endtask

task automatic check_bit(input string what, input logic actual, input logic expected);
  if (actual !== expected) begin
    report_mismatch($sformatf("%s is %b, expected %b", what, actual, expected));
  end
endtask

function automatic word_t random_word();
  return {$urandom, $urandom};
endfunction

function automatic mult_issue_t make_issue(input word_t opa, input word_t opb_reg,
                                           input imm_t imm, input logic imm_select,
                                           input rob_idx_t rob_idx, input pr_idx_t t_idx);
  mult_issue_t item;
  item.ready      = 1'b1;
  item.opa        = opa;
  item.opb_reg    = opb_reg;
  item.imm        = imm;
  item.imm_select = imm_select;
  // never equal to rob_idx, so a swapped tag shows
  item.dest_idx   = arch_reg_t'(~rob_idx);
  item.t_idx      = t_idx;
  item.rob_idx    = rob_idx;
  return item;
endfunction

// low 64 bits of opa times operand B, with the tags carried along
function automatic mult_result_t expected_result(input mult_issue_t item);
  mult_result_t exp;
  word_t        opb;
  if (item.imm_select) begin
    opb = {{(XLEN-IMM_W){1'b0}}, item.imm};
  end else begin
    opb = item.opb_reg;
  end
  exp.done     = 1'b1;
  exp.result   = item.opa * opb;
  exp.dest_idx = item.dest_idx;
  exp.t_idx    = item.t_idx;
  exp.rob_idx  = item.rob_idx;
  return exp;
endfunction

// offset past the rollback index against tail distance, both modulo the ROB size
function automatic logic in_rollback_span(input rob_idx_t rob, input rob_idx_t idx,
                                          input rob_idx_t tail);
  int offset;
  int window;
  offset = (int'(rob) - int'(idx) + ROB_ENTRIES) % ROB_ENTRIES;
  window = (int'(tail) - int'(idx) + ROB_ENTRIES) % ROB_ENTRIES;
  return offset <= window;
endfunction

task automatic match_result(input mult_result_t exp);
  check_word("result", result.result, exp.result);
  check_tags(result.rob_idx, exp.rob_idx, result.t_idx, exp.t_idx);
  check_dest(result.dest_idx, exp.dest_idx);
endtask

// called at a drive point, returns at the sample point of the same cycle
task automatic send_issue(input mult_issue_t item);
  issue = item;
  expected_q.push_back(expected_result(item));
  settle();
  check_bit("issue_accept", issue_accept, 1'b1);
endtask

task automatic await_result(input int max_cycles);
  int waited;
  waited = 0;
  settle();
  while (result.done !== 1'b1) begin
    waited++;
    if (waited > max_cycles) begin
      report_problem($sformatf("no result came out within %0d cycles", max_cycles));
    end
    tick();
    settle();
  end
endtask

// grant held high, every expected result must show up in order
task automatic collect_results(input int max_cycles);
  int waited;
  int quiet;
  waited = 0;
  while (expected_q.size() > 0) begin
    settle();
    if (result.done === 1'b1) begin
      match_result(expected_q.pop_front());
      waited = 0;
    end else begin
      waited++;
      if (waited > max_cycles) begin
        report_problem($sformatf("result for rob_idx %0d never came out",
                                 expected_q[0].rob_idx));
      end
    end
    tick();
  end
  // anything after the last one is lost order or a repeat
  for (quiet = 0; quiet < MULT_STAGES + 2; quiet++) begin
    settle();
    check_bit("result.done after drain", result.done, 1'b0);
    tick();
  end
endtask

task automatic apply_rollback(input rob_idx_t idx, input rob_idx_t tail);
  mult_result_t kept[$];
  rollback_en  = 1'b1;
  rollback_idx = idx;
  rob_tail_idx = tail;
  foreach (expected_q[i]) begin
    if (!in_rollback_span(expected_q[i].rob_idx, idx, tail)) begin
      kept.push_back(expected_q[i]);
    end
  end
  expected_q = kept;
  settle();
  tick();
  rollback_en = 1'b0;
endtask

task automatic idle_after_reset();
  settle();
  check_bit("result.done after reset", result.done, 1'b0);
  check_bit("issue_accept after reset", issue_accept, 1'b1);
endtask

task automatic single_multiply();
  tick();
  cdb_grant = 1'b1;
  send_issue(make_issue(random_word(), random_word(), '0, 1'b0, 5'd7, 6'd33));
  tick();
  issue = '0;
  // latency is fixed at one edge per stage
  for (int k = 1; k < MULT_STAGES; k++) begin
    settle();
    check_bit("result.done before latency", result.done, 1'b0);
    tick();
  end
  settle();
  check_bit("result.done at latency", result.done, 1'b1);
  match_result(expected_q.pop_front());
endtask

task automatic literal_operand();
  imm_t imm;
  // top bit set so a sign extension would show
  imm = imm_t'($urandom_range(255, 128));
  tick();
  // register value must be ignored
  send_issue(make_issue(random_word(), random_word(), imm, 1'b1, 5'd11, 6'd50));
  tick();
  issue = '0;
  collect_results(2 * MULT_STAGES);
endtask

task automatic back_to_back_stream();
  for (int i = 0; i < MULT_STAGES; i++) begin
    tick();
    send_issue(make_issue(random_word(), random_word(), '0, 1'b0,
                          rob_idx_t'(20 + i), pr_idx_t'(40 + i)));
  end
  tick();
  issue = '0;
  await_result(2 * MULT_STAGES);
  match_result(expected_q.pop_front());
  for (int i = 1; i < MULT_STAGES; i++) begin
    tick();
    settle();
    check_bit("result.done in stream", result.done, 1'b1);
    match_result(expected_q.pop_front());
  end
  tick();
  settle();
  check_bit("result.done after stream", result.done, 1'b0);
endtask

task automatic backpressure_hold();
  mult_result_t held;
  mult_issue_t  late;
  late = make_issue(random_word(), random_word(), '0, 1'b0, 5'd30, 6'd3);
  tick();
  cdb_grant = 1'b0;
  for (int i = 0; i < 3; i++) begin
    if (i > 0) begin
      tick();
    end
    send_issue(make_issue(random_word(), random_word(), '0, 1'b0,
                          rob_idx_t'(i + 1), pr_idx_t'(i + 10)));
  end
  tick();
  issue = '0;
  await_result(2 * MULT_STAGES);
  match_result(expected_q[0]);
  held = result;
  // late issue waits at the input for the whole stall
  for (int s = 0; s < 5; s++) begin
    tick();
    issue = late;
    settle();
    check_bit("result.done while stalled", result.done, 1'b1);
    check_word("stalled result", result.result, held.result);
    check_tags(result.rob_idx, held.rob_idx, result.t_idx, held.t_idx);
    check_dest(result.dest_idx, held.dest_idx);
    check_bit("issue_accept while stalled", issue_accept, 1'b0);
  end
  tick();
  cdb_grant = 1'b1;
  expected_q.push_back(expected_result(late));
  settle();
  check_bit("issue_accept on grant", issue_accept, 1'b1);
  match_result(expected_q.pop_front());
  tick();
  issue = '0;
  collect_results(2 * MULT_STAGES);
endtask

task automatic rollback_squash();
  tick();
  cdb_grant = 1'b1;
  send_issue(make_issue(random_word(), random_word(), '0, 1'b0, 5'd3, 6'd21));
  tick();
  send_issue(make_issue(random_word(), random_word(), '0, 1'b0, 5'd5, 6'd22));
  tick();
  send_issue(make_issue(random_word(), random_word(), '0, 1'b0, 5'd9, 6'd23));
  tick();
  issue = '0;
  // 5 and 9 lie in the span from 5 up to tail 12
  apply_rollback(5'd5, 5'd12);
  collect_results(2 * MULT_STAGES);
endtask

`endif

// ==== verification/mult_unit_tb.sv ====
`timescale 1ns/1ps

module mult_unit_tb import mult_pkg::*; ();

  localparam int CLOCK_PERIOD    = 20;
  localparam int RESET_CYCLES    = 4;
  // each directed test fits in a few pipeline depths
  localparam int TEST_COUNT      = 6;
  localparam int CYCLES_PER_TEST = 4 * MULT_STAGES + 8;
  localparam int MARGIN_CYCLES   = 50;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + TEST_COUNT * CYCLES_PER_TEST + MARGIN_CYCLES;
  // inputs change this long after the rising edge
  localparam int DRIVE_DELAY     = 1;

  logic         clock = 1'b0;
  logic         reset;
  mult_issue_t  issue;
  logic         cdb_grant;
  logic         rollback_en;
  rob_idx_t     rollback_idx;
  rob_idx_t     rob_tail_idx;
  mult_result_t result;
  logic         issue_accept;

  // results still owed by the DUT, oldest first
  mult_result_t expected_q[$];

  always #(CLOCK_PERIOD / 2) clock = ~clock;

  mult_unit mult_unit_inst (
    .clock        (clock),
    .reset        (reset),
    .issue        (issue),
    .cdb_grant    (cdb_grant),
    .rollback_en  (rollback_en),
    .rollback_idx (rollback_idx),
    .rob_tail_idx (rob_tail_idx),
    .result       (result),
    .issue_accept (issue_accept)
  );

  `include "mult_tb_tasks.svh"

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin : test_sequence
    void'($urandom(21));
    reset        = 1'b1;
    issue        = '0;
    cdb_grant    = 1'b0;
    rollback_en  = 1'b0;
    rollback_idx = '0;
    rob_tail_idx = '0;

    repeat (RESET_CYCLES) @(posedge clock);
    #(DRIVE_DELAY);
    reset = 1'b0;

    idle_after_reset();
    single_multiply();
    literal_operand();
    back_to_back_stream();
    backpressure_hold();
    rollback_squash();

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
